// File: hw/rvCorePkg.sv
package rvCorePkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdxT;
  typedef logic [11:0] csrAddrT;
  typedef logic [3:0]  aluOpT;
  typedef logic [1:0]  wbSelT;

  localparam aluOpT ALU_ADD   = 4'd0;
  localparam aluOpT ALU_SUB   = 4'd1;
  localparam aluOpT ALU_SLL   = 4'd2;
  localparam aluOpT ALU_SLT   = 4'd3;
  localparam aluOpT ALU_SLTU  = 4'd4;
  localparam aluOpT ALU_XOR   = 4'd5;
  localparam aluOpT ALU_SRL   = 4'd6;
  localparam aluOpT ALU_SRA   = 4'd7;
  localparam aluOpT ALU_OR    = 4'd8;
  localparam aluOpT ALU_AND   = 4'd9;
  localparam aluOpT ALU_COPYB = 4'd10;

  localparam wbSelT WB_ALU = 2'd0;
  localparam wbSelT WB_MEM = 2'd1;
  localparam wbSelT WB_PC4 = 2'd2;
  localparam wbSelT WB_CSR = 2'd3;

  // operand B sources, zero is the fall-through entry
  localparam logic [1:0] BSEL_REG  = 2'd0;
  localparam logic [1:0] BSEL_IMM  = 2'd1;
  localparam logic [1:0] BSEL_CSR  = 2'd2;
  localparam logic [1:0] BSEL_ZERO = 2'd3;

  // access size, matches funct3[1:0] of loads and stores
  localparam logic [1:0] MEM_BYTE = 2'd0;
  localparam logic [1:0] MEM_HALF = 2'd1;
  localparam logic [1:0] MEM_WORD = 2'd2;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam wordT RESET_PC   = 32'h0;
  localparam int   DMEM_WORDS = 256;
  localparam int   DMEM_AW    = $clog2(DMEM_WORDS);

  localparam csrAddrT CSR_MTVEC  = 12'h305;
  localparam csrAddrT CSR_MEPC   = 12'h341;
  localparam csrAddrT CSR_MCAUSE = 12'h342;
  localparam wordT    MCAUSE_ECALL = 32'd11;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_HOLD
  } fetchStateT;

  typedef struct packed {
    wordT pc;
    wordT inst;
  } fetchPktT;

  typedef struct packed {
    aluOpT      aluOp;
    logic       aluASel;
    logic [1:0] aluBSel;
    logic       memRead;
    logic       memWrite;
    logic [1:0] memSize;
    logic       memUnsigned;
    logic       regWrite;
    wbSelT      wbSel;
    logic       csrWrite;
    logic       csrSet;
    logic       branch;
    logic [2:0] brFunct;
    logic       jump;
    logic       jalr;
    logic       ecall;
    logic       mret;
    logic       ebreak;
    regIdxT     rd;
    regIdxT     rs1;
    regIdxT     rs2;
    wordT       imm;
    csrAddrT    csrId;
  } ctrlT;

  typedef struct packed {
    wordT   pc;
    regIdxT rd;
    wordT   data;
    logic   regWrite;
  } commitT;

endpackage

// File: hw/rvFetch.sv
module rvFetch
  import rvCorePkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  wordT     inst,
  input  logic     instValid,
  input  logic     iduReady,
  input  wordT     nextPc,
  output wordT     instAddr,
  output fetchPktT fetchPkt,
  output logic     ifuValid
);

  fetchStateT state;
  wordT       pc;

  assign instAddr = pc;
  assign ifuValid = (state == FETCH_HOLD);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FETCH_IDLE;
      pc    <= RESET_PC;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (instValid) begin
            state <= FETCH_HOLD;
          end
        end
        FETCH_HOLD: begin
          // instruction retires on this edge, move on
          if (iduReady) begin
            state <= FETCH_IDLE;
            pc    <= nextPc;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // packet is held untouched while waiting for writeback
  always_ff @(posedge clk) begin
    if (state == FETCH_IDLE && instValid) begin
      fetchPkt.pc   <= pc;
      fetchPkt.inst <= inst;
    end
  end

endmodule

// File: hw/rvDecode.sv
module rvDecode
  import rvCorePkg::*;
(
  input  wordT inst,
  output ctrlT ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       altOp;
  wordT       immI;
  wordT       immS;
  wordT       immB;
  wordT       immU;
  wordT       immJ;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  // funct7 bit 5 picks sub and sra
  assign altOp  = inst[30];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl       = '0;
    ctrl.rd    = inst[11:7];
    ctrl.rs1   = inst[19:15];
    ctrl.rs2   = inst[24:20];
    ctrl.csrId = inst[31:20];
    ctrl.imm   = immI;

    case (opcode)
      OP_LUI: begin
        ctrl.aluOp    = ALU_COPYB;
        ctrl.aluBSel  = BSEL_IMM;
        ctrl.imm      = immU;
        ctrl.regWrite = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.aluASel  = 1'b1;
        ctrl.aluBSel  = BSEL_IMM;
        ctrl.imm      = immU;
        ctrl.regWrite = 1'b1;
      end
      OP_JAL: begin
        ctrl.aluASel  = 1'b1;
        ctrl.aluBSel  = BSEL_IMM;
        ctrl.imm      = immJ;
        ctrl.jump     = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = WB_PC4;
      end
      OP_JALR: begin
        ctrl.aluBSel  = BSEL_IMM;
        ctrl.jump     = 1'b1;
        ctrl.jalr     = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = WB_PC4;
      end
      OP_BRANCH: begin
        // target is pc + imm, comparator decides
        ctrl.aluASel = 1'b1;
        ctrl.aluBSel = BSEL_IMM;
        ctrl.imm     = immB;
        ctrl.branch  = 1'b1;
        ctrl.brFunct = funct3;
      end
      OP_LOAD: begin
        ctrl.aluBSel     = BSEL_IMM;
        ctrl.memRead     = 1'b1;
        ctrl.memSize     = funct3[1:0];
        ctrl.memUnsigned = funct3[2];
        ctrl.regWrite    = 1'b1;
        ctrl.wbSel       = WB_MEM;
      end
      OP_STORE: begin
        ctrl.aluBSel  = BSEL_IMM;
        ctrl.imm      = immS;
        ctrl.memWrite = 1'b1;
        ctrl.memSize  = funct3[1:0];
      end
      OP_IMM, OP_REG: begin
        ctrl.aluBSel  = (opcode == OP_REG) ? BSEL_REG : BSEL_IMM;
        ctrl.regWrite = 1'b1;
        case (funct3)
          3'b000:  ctrl.aluOp = (opcode == OP_REG && altOp) ? ALU_SUB : ALU_ADD;
          3'b001:  ctrl.aluOp = ALU_SLL;
          3'b010:  ctrl.aluOp = ALU_SLT;
          3'b011:  ctrl.aluOp = ALU_SLTU;
          3'b100:  ctrl.aluOp = ALU_XOR;
          3'b101:  ctrl.aluOp = altOp ? ALU_SRA : ALU_SRL;
          3'b110:  ctrl.aluOp = ALU_OR;
          default: ctrl.aluOp = ALU_AND;
        endcase
      end
      OP_SYSTEM: begin
        if (funct3 == 3'b000) begin
          ctrl.ecall  = (inst[31:20] == 12'h000);
          ctrl.ebreak = (inst[31:20] == 12'h001);
          ctrl.mret   = (inst[31:20] == 12'h302);
        end else if (funct3 == 3'b001 || funct3 == 3'b010) begin
          // csrrw passes rs1 through, csrrs ors it into the old value
          ctrl.csrSet   = funct3[1];
          ctrl.aluOp    = ALU_OR;
          ctrl.aluBSel  = funct3[1] ? BSEL_CSR : BSEL_ZERO;
          ctrl.csrWrite = 1'b1;
          ctrl.regWrite = 1'b1;
          ctrl.wbSel    = WB_CSR;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: hw/rvExecute.sv
module rvExecute
  import rvCorePkg::*;
(
  input  logic     clk,
  input  logic     fire,
  input  fetchPktT fetchPkt,
  input  ctrlT     ctrl,
  input  wordT     regData1,
  input  wordT     regData2,
  input  wordT     csrReadData,
  input  wordT     mtvec,
  input  wordT     mepc,
  output wordT     aluOut,
  output wordT     memDataR,
  output wordT     snpc,
  output wordT     dnpc
);

  wordT               opA;
  wordT               opB;
  logic               brTaken;
  wordT               dmem [DMEM_WORDS];
  logic [DMEM_AW-1:0] wordIdx;
  logic [1:0]         byteOff;
  wordT               rdWord;
  wordT               rdShifted;
  wordT               wrData;
  logic [3:0]         wrMask;

  assign opA = ctrl.aluASel ? fetchPkt.pc : regData1;

  always_comb begin
    case (ctrl.aluBSel)
      BSEL_REG: opB = regData2;
      BSEL_IMM: opB = ctrl.imm;
      BSEL_CSR: opB = csrReadData;
      default:  opB = '0;
    endcase
  end

  always_comb begin
    case (ctrl.aluOp)
      ALU_SUB:   aluOut = opA - opB;
      ALU_SLL:   aluOut = opA << opB[4:0];
      ALU_SLT:   aluOut = {31'b0, $signed(opA) < $signed(opB)};
      ALU_SLTU:  aluOut = {31'b0, opA < opB};
      ALU_XOR:   aluOut = opA ^ opB;
      ALU_SRL:   aluOut = opA >> opB[4:0];
      ALU_SRA:   aluOut = $signed(opA) >>> opB[4:0];
      ALU_OR:    aluOut = opA | opB;
      ALU_AND:   aluOut = opA & opB;
      ALU_COPYB: aluOut = opB;
      default:   aluOut = opA + opB;
    endcase
  end

  // branch comparator always works on the two register operands
  always_comb begin
    case (ctrl.brFunct)
      3'b000:  brTaken = (regData1 == regData2);
      3'b001:  brTaken = (regData1 != regData2);
      3'b100:  brTaken = ($signed(regData1) < $signed(regData2));
      3'b101:  brTaken = ($signed(regData1) >= $signed(regData2));
      3'b110:  brTaken = (regData1 < regData2);
      3'b111:  brTaken = (regData1 >= regData2);
      default: brTaken = 1'b0;
    endcase
  end

  assign snpc = fetchPkt.pc + 32'd4;

  always_comb begin
    if (ctrl.mret) begin
      dnpc = mepc;
    end else if (ctrl.ecall) begin
      dnpc = mtvec;
    end else if (ctrl.jump || (ctrl.branch && brTaken)) begin
      dnpc = ctrl.jalr ? {aluOut[31:1], 1'b0} : aluOut;
    end else begin
      dnpc = snpc;
    end
  end

  // data memory, word index plus byte lane
  assign wordIdx   = aluOut[DMEM_AW+1:2];
  assign byteOff   = aluOut[1:0];
  assign rdWord    = dmem[wordIdx];
  assign rdShifted = rdWord >> {byteOff, 3'b000};

  always_comb begin
    if (!ctrl.memRead) begin
      memDataR = '0;
    end else begin
      case (ctrl.memSize)
        MEM_BYTE: memDataR = ctrl.memUnsigned ? {24'b0, rdShifted[7:0]}
                                              : {{24{rdShifted[7]}}, rdShifted[7:0]};
        MEM_HALF: memDataR = ctrl.memUnsigned ? {16'b0, rdShifted[15:0]}
                                              : {{16{rdShifted[15]}}, rdShifted[15:0]};
        default:  memDataR = rdWord;
      endcase
    end
  end

  assign wrData = regData2 << {byteOff, 3'b000};

  always_comb begin
    case (ctrl.memSize)
      MEM_BYTE: wrMask = 4'b0001 << byteOff;
      MEM_HALF: wrMask = 4'b0011 << byteOff;
      default:  wrMask = 4'b1111;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fire && ctrl.memWrite) begin
      for (int b = 0; b < 4; b++) begin
        if (wrMask[b]) begin
          dmem[wordIdx][8*b +: 8] <= wrData[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: hw/rvRegFile.sv
module rvRegFile
  import rvCorePkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  regIdxT  rs1,
  input  regIdxT  rs2,
  output wordT    regData1,
  output wordT    regData2,
  input  logic    regWrite,
  input  regIdxT  rd,
  input  wordT    regDataWB,
  input  csrAddrT csrId,
  output wordT    csrReadData,
  input  logic    csrWrite,
  input  wordT    csrWriteData,
  input  logic    ecall,
  input  wordT    pc,
  output wordT    mtvec,
  output wordT    mepc
);

  // entry 0 is cleared by reset and never written
  wordT regs [32];
  wordT mtvecReg;
  wordT mepcReg;
  wordT mcauseReg;

  assign regData1 = regs[rs1];
  assign regData2 = regs[rs2];
  assign mtvec    = mtvecReg;
  assign mepc     = mepcReg;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && rd != '0) begin
      regs[rd] <= regDataWB;
    end
  end

  always_comb begin
    case (csrId)
      CSR_MTVEC:  csrReadData = mtvecReg;
      CSR_MEPC:   csrReadData = mepcReg;
      CSR_MCAUSE: csrReadData = mcauseReg;
      default:    csrReadData = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mtvecReg  <= '0;
      mepcReg   <= '0;
      mcauseReg <= '0;
    end else if (ecall) begin
      // trap entry wins over any csr write
      mepcReg   <= pc;
      mcauseReg <= MCAUSE_ECALL;
    end else if (csrWrite) begin
      case (csrId)
        CSR_MTVEC:  mtvecReg  <= csrWriteData;
        CSR_MEPC:   mepcReg   <= csrWriteData;
        CSR_MCAUSE: mcauseReg <= csrWriteData;
        default: ;
      endcase
    end
  end

endmodule

// File: hw/rvWriteback.sv
module rvWriteback
  import rvCorePkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     mfuValid,
  output logic     wbuReady,
  output logic     fire,
  input  fetchPktT fetchPkt,
  input  ctrlT     ctrl,
  input  wordT     aluOut,
  input  wordT     memDataR,
  input  wordT     snpc,
  input  wordT     csrReadData,
  output logic     regWrite,
  output wordT     regDataWB,
  output logic     csrWrite,
  output logic     commitValid,
  output commitT   commit,
  output logic     halt
);

  logic rdWritten;

  assign wbuReady = ~halt;
  assign fire     = mfuValid & wbuReady;

  always_comb begin
    case (ctrl.wbSel)
      WB_MEM:  regDataWB = memDataR;
      WB_PC4:  regDataWB = snpc;
      WB_CSR:  regDataWB = csrReadData;
      default: regDataWB = aluOut;
    endcase
  end

  assign regWrite = fire & ctrl.regWrite;
  // csrrs with rs1 = x0 only reads
  assign csrWrite = fire & ctrl.csrWrite & (~ctrl.csrSet | (ctrl.rs1 != '0));

  assign rdWritten = ctrl.regWrite & (ctrl.rd != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      commitValid <= 1'b0;
      halt        <= 1'b0;
    end else begin
      commitValid <= fire;
      if (fire && ctrl.ebreak) begin
        halt <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      commit.pc       <= fetchPkt.pc;
      commit.rd       <= ctrl.regWrite ? ctrl.rd : '0;
      commit.data     <= rdWritten ? regDataWB : '0;
      commit.regWrite <= ctrl.regWrite;
    end
  end

endmodule

// File: hw/rvCore.sv
module rvCore
  import rvCorePkg::*;
(
  input  logic   clk,
  input  logic   reset,
  output wordT   instAddr,
  input  wordT   inst,
  input  logic   instValid,
  output logic   commitValid,
  output commitT commit,
  output logic   halt
);

  fetchPktT fetchPkt;
  ctrlT     ctrl;
  logic     ifuValid;
  logic     wbuReady;
  logic     fire;
  logic     regWrite;
  logic     csrWrite;
  logic     ecallFire;
  wordT     regData1;
  wordT     regData2;
  wordT     csrReadData;
  wordT     mtvec;
  wordT     mepc;
  wordT     aluOut;
  wordT     memDataR;
  wordT     snpc;
  wordT     dnpc;
  wordT     regDataWB;

  // trap entry only at the retiring edge
  assign ecallFire = fire & ctrl.ecall;

  rvFetch i_rvFetch (
    .clk       (clk),
    .reset     (reset),
    .inst      (inst),
    .instValid (instValid),
    .iduReady  (wbuReady),
    .nextPc    (dnpc),
    .instAddr  (instAddr),
    .fetchPkt  (fetchPkt),
    .ifuValid  (ifuValid)
  );

  rvDecode i_rvDecode (
    .inst (fetchPkt.inst),
    .ctrl (ctrl)
  );

  rvExecute i_rvExecute (
    .clk         (clk),
    .fire        (fire),
    .fetchPkt    (fetchPkt),
    .ctrl        (ctrl),
    .regData1    (regData1),
    .regData2    (regData2),
    .csrReadData (csrReadData),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .aluOut      (aluOut),
    .memDataR    (memDataR),
    .snpc        (snpc),
    .dnpc        (dnpc)
  );

  rvRegFile i_rvRegFile (
    .clk          (clk),
    .reset        (reset),
    .rs1          (ctrl.rs1),
    .rs2          (ctrl.rs2),
    .regData1     (regData1),
    .regData2     (regData2),
    .regWrite     (regWrite),
    .rd           (ctrl.rd),
    .regDataWB    (regDataWB),
    .csrId        (ctrl.csrId),
    .csrReadData  (csrReadData),
    .csrWrite     (csrWrite),
    .csrWriteData (aluOut),
    .ecall        (ecallFire),
    .pc           (fetchPkt.pc),
    .mtvec        (mtvec),
    .mepc         (mepc)
  );

  rvWriteback i_rvWriteback (
    .clk         (clk),
    .reset       (reset),
    .mfuValid    (ifuValid),
    .wbuReady    (wbuReady),
    .fire        (fire),
    .fetchPkt    (fetchPkt),
    .ctrl        (ctrl),
    .aluOut      (aluOut),
    .memDataR    (memDataR),
    .snpc        (snpc),
    .csrReadData (csrReadData),
    .regWrite    (regWrite),
    .regDataWB   (regDataWB),
    .csrWrite    (csrWrite),
    .commitValid (commitValid),
    .commit      (commit),
    .halt        (halt)
  );

endmodule

// File: test/rvCore_chk.sv
module rvCore_chk (
  input logic clk,
  input logic reset,
  input logic commitValid,
  input logic halt,
  input logic ifuValid,
  input logic fire
);

  // one instruction in flight, so commits never come back to back
  assert property (@(posedge clk) disable iff (reset) commitValid |=> !commitValid)
    else $error("commitValid was high in two consecutive cycles");

  assert property (@(posedge clk) disable iff (reset) $past(halt) |-> !commitValid)
    else $error("an instruction committed after halt was raised");

  assert property (@(posedge clk) disable iff (reset) (ifuValid && !fire) |=> ifuValid)
    else $error("ifuValid dropped before the instruction retired");

endmodule

bind rvCore rvCore_chk i_rvCoreChk (
  .clk         (clk),
  .reset       (reset),
  .commitValid (commitValid),
  .halt        (halt),
  .ifuValid    (ifuValid),
  .fire        (fire)
);

// File: test/rvCoreChecker.sv
module rvCoreChecker
  import rvCorePkg::*;
#(
  parameter int MaxExp   = 128,
  parameter int MaxTests = 16
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         commitValid,
  input  commitT       commit,
  input  logic         halt,
  input  int           expCount,
  input  logic         haltExpected,
  input  wordT         expPc [MaxExp],
  input  regIdxT       expRd [MaxExp],
  input  wordT         expData [MaxExp],
  input  logic         expWrite [MaxExp],
  input  int           expTest [MaxExp],
  input  logic [127:0] testNames [MaxTests],
  output int           passCount,
  output int           failCount,
  output int           errorCount,
  output logic         done
);

  int     idx;
  logic   testBad;
  logic   haltSeen;
  commitT badExp;
  commitT badAct;

  function automatic string recordText(input commitT r);
    return $sformatf("pc=%08h rd=%0d data=%08h wr=%0b", r.pc, r.rd, r.data, r.regWrite);
  endfunction

  initial begin
    idx        = 0;
    testBad    = 1'b0;
    haltSeen   = 1'b0;
    passCount  = 0;
    failCount  = 0;
    errorCount = 0;
  end

  always @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      if (commitValid) begin
        if (idx >= expCount) begin
          $display("ERROR: a commit at pc %08h arrived after the expected trace ended",
                   commit.pc);
          errorCount++;
        end else begin
          // keep only the first mismatch of a test
          if (!testBad && (commit.pc != expPc[idx] || commit.rd != expRd[idx] ||
                           commit.data != expData[idx] ||
                           commit.regWrite != expWrite[idx])) begin
            testBad         = 1'b1;
            badExp.pc       = expPc[idx];
            badExp.rd       = expRd[idx];
            badExp.data     = expData[idx];
            badExp.regWrite = expWrite[idx];
            badAct          = commit;
          end
          // last record of this test
          if (idx + 1 == expCount || expTest[idx + 1] != expTest[idx]) begin
            if (testBad) begin
              $display("FAIL %0s expected %0s actual %0s", testNames[expTest[idx]],
                       recordText(badExp), recordText(badAct));
              failCount++;
            end else begin
              $display("PASS %0s", testNames[expTest[idx]]);
              passCount++;
            end
            testBad = 1'b0;
          end
          idx++;
        end
      end
      if (halt && !haltSeen) begin
        haltSeen = 1'b1;
        if (idx < expCount || !haltExpected) begin
          $display("ERROR: the core halted before the expected trace ended");
          errorCount++;
        end
        done <= 1'b1;
      end
    end
  end

endmodule

// File: test/rvCoreTb.sv
module rvCoreTb
  import rvCorePkg::*;
();

  localparam int MaxExp   = 128;
  localparam int MaxTests = 16;

  logic         clk = 1'b0;
  logic         reset;
  wordT         instAddr;
  wordT         inst;
  logic         instValid;
  logic         commitValid;
  commitT       commit;
  logic         halt;
  wordT         prog [256];
  wordT         expPc [MaxExp];
  regIdxT       expRd [MaxExp];
  wordT         expData [MaxExp];
  logic         expWrite [MaxExp];
  int           expTest [MaxExp];
  logic [127:0] testNames [MaxTests];
  int           expCount;
  int           testCount;
  logic         haltExpected;
  int           passCount;
  int           failCount;
  int           errorCount;
  logic         done;
  logic [31:0]  lfsr;

  rvCore i_rvCore (
    .clk         (clk),
    .reset       (reset),
    .instAddr    (instAddr),
    .inst        (inst),
    .instValid   (instValid),
    .commitValid (commitValid),
    .commit      (commit),
    .halt        (halt)
  );

  rvCoreChecker #(.MaxExp(MaxExp), .MaxTests(MaxTests)) i_rvCoreChecker (
    .clk          (clk),
    .reset        (reset),
    .commitValid  (commitValid),
    .commit       (commit),
    .halt         (halt),
    .expCount     (expCount),
    .haltExpected (haltExpected),
    .expPc        (expPc),
    .expRd        (expRd),
    .expData      (expData),
    .expWrite     (expWrite),
    .expTest      (expTest),
    .testNames    (testNames),
    .passCount    (passCount),
    .failCount    (failCount),
    .errorCount   (errorCount),
    .done         (done)
  );

  // taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // RV32I formats that carry a destination register
  function automatic logic writesRd(input wordT w);
    case (w[6:0])
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG: return 1'b1;
      OP_SYSTEM: return w[14:12] != 3'b000;
      default:   return 1'b0;
    endcase
  endfunction

  always #4 clk = ~clk;

  // inputs change on the falling edge only
  always @(negedge clk) begin
    logic bitA;
    logic bitB;
    lfsr = lfsrNext(lfsr);
    bitA = lfsr[0];
    lfsr = lfsrNext(lfsr);
    bitB = lfsr[0];
    instValid = !(bitA == 1'b0 && bitB == 1'b0);
    inst = prog[instAddr[9:2]];
  end

  task automatic loadPatterns(output logic ok);
    int    fd;
    int    progCount;
    wordT  w;
    wordT  a;
    wordT  b;
    wordT  c;
    string line;
    logic [127:0] name;
    progCount = 0;
    ok = 1'b1;
    fd = $fopen("test/rvCorePatterns.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the pattern file");
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0) continue;
      if (line[0] == "I") begin
        void'($sscanf(line, "I %h", w));
        prog[progCount] = w;
        progCount++;
      end else if (line[0] == "T") begin
        void'($sscanf(line, "T %s", name));
        testNames[testCount] = name;
        testCount++;
      end else if (line[0] == "E") begin
        void'($sscanf(line, "E %h %h %h", a, b, c));
        expPc[expCount]   = a;
        expRd[expCount]   = b[4:0];
        expData[expCount] = c;
        expTest[expCount] = testCount - 1;
        expCount++;
      end else if (line[0] == "H") begin
        haltExpected = 1'b1;
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int   limit;
    int   cycles;
    logic fileOk;
    logic timedOut;
    reset        = 1'b1;
    instValid    = 1'b0;
    inst         = '0;
    lfsr         = 32'h1b9eb5d1;
    expCount     = 0;
    testCount    = 0;
    haltExpected = 1'b0;
    timedOut     = 1'b0;
    // unused words are nops tagged with their own index
    for (int i = 0; i < 256; i++) begin
      prog[i] = {i[11:0], 20'h00013};
    end
    loadPatterns(fileOk);
    // destination write expected from the opcode of each traced instruction
    for (int i = 0; i < expCount; i++) begin
      expWrite[i] = writesRd(prog[expPc[i][9:2]]);
    end
    limit = 4 * expCount + 50;

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    if (fileOk) begin
      cycles = 0;
      while (!done && cycles < limit) begin
        @(posedge clk);
        cycles++;
      end
      if (!done) begin
        $display("ERROR: timeout, the core did not halt within %0d cycles", limit);
        timedOut = 1'b1;
      end else begin
        // stray commits after halt still get caught
        repeat (8) @(posedge clk);
      end
    end

    $display("tests passed %0d failed %0d", passCount, testCount - passCount);
    if (fileOk && !timedOut && failCount == 0 && errorCount == 0 &&
        passCount == testCount) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: test/rvCorePatterns.txt
# I <word>: program word, in address order from pc 0
# T <name>: start of a named test; E <pc> <rd> <data>: expected commit; H: halt expected
T alu
I 00500093
I FFD00113
I 123451B7
I 00001217
I 001122B3
I 00113333
I 00309393
I 40115413
I 01C15493
I 0020C533
I 402085B3
I 0F00E613
I 00A676B3
I 00708013
E 00000000 01 00000005
E 00000004 02 FFFFFFFD
E 00000008 03 12345000
E 0000000C 04 0000100C
E 00000010 05 00000001
E 00000014 06 00000000
E 00000018 07 00000028
E 0000001C 08 FFFFFFFE
E 00000020 09 0000000F
E 00000024 0A FFFFFFF8
E 00000028 0B 00000008
E 0000002C 0C 000000F5
E 00000030 0D 000000F0
E 00000034 00 00000000
T mem
I 10000713
I 89ABD7B7
I DEF78793
I 00F72023
I 001700A3
I 00271123
I 00072803
I 00070883
I 00074903
I 00271983
I 00275A03
I 00170A83
E 00000038 0E 00000100
E 0000003C 0F 89ABD000
E 00000040 0F 89ABCDEF
E 00000044 00 00000000
E 00000048 00 00000000
E 0000004C 00 00000000
E 00000050 10 FFFD05EF
E 00000054 11 FFFFFFEF
E 00000058 12 000000EF
E 0000005C 13 FFFFFFFD
E 00000060 14 0000FFFD
E 00000064 15 00000005
T branch
I 00108463
I 00100B13
I 00109463
I 00114463
I 00100B13
I 00115463
I 00116463
I 00117463
I 00100B13
I 00800BEF
I 00100B13
I 0A400C13
I 000C0CE7
I 00100B13
I 00100B13
E 00000068 00 00000000
E 00000070 00 00000000
E 00000074 00 00000000
E 0000007C 00 00000000
E 00000080 00 00000000
E 00000084 00 00000000
E 0000008C 17 00000090
E 00000094 18 000000A4
E 00000098 19 0000009C
T csr
I 0C000D13
I 305D1DF3
I 30502E73
I 00000073
I 34102FF3
I 00100073
I 00100B13
I 34102EF3
I 34202F73
I 004E8E93
I 341E9073
I 30200073
E 000000A4 1A 000000C0
E 000000A8 1B 00000000
E 000000AC 1C 000000C0
E 000000B0 00 00000000
E 000000C0 1D 000000B0
E 000000C4 1E 0000000B
E 000000C8 1D 000000B4
E 000000CC 00 00000000
E 000000D0 00 00000000
T halt
E 000000B4 1F 000000B4
E 000000B8 00 00000000
H

// File: list.f
hw/rvCorePkg.sv
hw/rvFetch.sv
hw/rvDecode.sv
hw/rvExecute.sv
hw/rvRegFile.sv
hw/rvWriteback.sv
hw/rvCore.sv
test/rvCore_chk.sv
test/rvCoreChecker.sv
test/rvCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rvCoreTb
FLIST     ?= list.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  := *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
